// ==== src.f ====
rtl/ramen_pkg.sv
rtl/order_ctrl.sv
rtl/ingredient_stock.sv
rtl/sales_ledger.sv
rtl/ramen_top.sv
bench/ramen_chk.sv
bench/ramen_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ramen_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --assert --timing
SIM_ARGS  ?=

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary -j $(JOBS) $(VFLAGS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(OBJ_DIR)

# a $fatal in the run gives a nonzero exit status
sim: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/ramen_tb.sv ====
`default_nettype none

module ramen_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SESSIONS    = 7;
    localparam int MAX_ORDERS  = 8 + 23 + 3 + 4 * 60;
    localparam int CYCLE_LIMIT = (SESSIONS + MAX_ORDERS) * 8 + 200;
    localparam int WAIT_LIMIT  = 16;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    logic                   selling;
    logic                   portion;
    ramen_pkg::ramen_type_t ramen_type;
    logic                   out_valid_order;
    logic                   success;
    logic                   out_valid_tot;
    ramen_pkg::sold_num_t   sold_num;
    ramen_pkg::gain_t       total_gain;

    ramen_pkg::stock_t    model_stock;
    ramen_pkg::sold_num_t model_counts;
    ramen_pkg::gain_t     model_gain;

    logic                 exp_success[$];
    ramen_pkg::sold_num_t exp_sold[$];
    ramen_pkg::gain_t     exp_gain[$];
    int                   orders_seen = 0;
    int                   totals_seen = 0;
    int                   cycles = 0;
    logic [31:0]          lfsr;
    string                test_name;

    ramen_top uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .selling         (selling),
        .portion         (portion),
        .ramen_type      (ramen_type),
        .out_valid_order (out_valid_order),
        .success         (success),
        .out_valid_tot   (out_valid_tot),
        .sold_num        (sold_num),
        .total_gain      (total_gain)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_failed();
        $display("Testbench failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("run did not finish within %0d cycles", CYCLE_LIMIT);
            stop_failed();
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic int take_bits(int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    // noodle, broth, soup, miso, soy per bowl and portion
    function automatic ramen_pkg::stock_t bowl_need(ramen_pkg::order_t o);
        ramen_pkg::stock_t n;
        case ({o.bowl, o.portion})
            3'b000:  n = '{14'd100, 16'd300, 14'd150, 10'd0, 11'd0};
            3'b001:  n = '{14'd150, 16'd500, 14'd200, 10'd0, 11'd0};
            3'b010:  n = '{14'd100, 16'd300, 14'd100, 10'd0, 11'd30};
            3'b011:  n = '{14'd150, 16'd500, 14'd150, 10'd0, 11'd50};
            3'b100:  n = '{14'd100, 16'd400, 14'd0, 10'd30, 11'd0};
            3'b101:  n = '{14'd150, 16'd650, 14'd0, 10'd50, 11'd0};
            3'b110:  n = '{14'd100, 16'd300, 14'd70, 10'd15, 11'd15};
            default: n = '{14'd150, 16'd500, 14'd100, 10'd25, 11'd25};
        endcase
        return n;
    endfunction

    // reference model of one order against the running stock and ledger
    function automatic logic serve_order(ramen_pkg::order_t o);
        ramen_pkg::stock_t n;
        logic              ok;
        n  = bowl_need(o);
        ok = model_stock.noodle >= n.noodle && model_stock.broth >= n.broth &&
             model_stock.soup >= n.soup && model_stock.miso >= n.miso &&
             model_stock.soy >= n.soy;
        if (ok) begin
            model_stock.noodle = model_stock.noodle - n.noodle;
            model_stock.broth  = model_stock.broth - n.broth;
            model_stock.soup   = model_stock.soup - n.soup;
            model_stock.miso   = model_stock.miso - n.miso;
            model_stock.soy    = model_stock.soy - n.soy;
            case (o.bowl)
                ramen_pkg::tonkotsu: begin
                    model_counts.tonkotsu = model_counts.tonkotsu + 7'd1;
                    model_gain = model_gain + 15'd200;
                end
                ramen_pkg::tonkotsu_soy: begin
                    model_counts.tonkotsu_soy = model_counts.tonkotsu_soy + 7'd1;
                    model_gain = model_gain + 15'd250;
                end
                ramen_pkg::miso: begin
                    model_counts.miso = model_counts.miso + 7'd1;
                    model_gain = model_gain + 15'd200;
                end
                default: begin
                    model_counts.miso_soy = model_counts.miso_soy + 7'd1;
                    model_gain = model_gain + 15'd250;
                end
            endcase
        end
        return ok;
    endfunction

    task automatic check_order(logic expected, logic actual);
        if (actual !== expected) begin
            $display("Error: %s order %0d success expected %0b actual %0b",
                     test_name, orders_seen, expected, actual);
            stop_failed();
        end
    endtask

    task automatic check_total(ramen_pkg::sold_num_t exp_n, ramen_pkg::gain_t exp_g,
                               ramen_pkg::sold_num_t act_n, ramen_pkg::gain_t act_g);
        if (act_n !== exp_n || act_g !== exp_g) begin
            $display("Error: %s report expected sold %h gain %0d actual sold %h gain %0d",
                     test_name, exp_n, exp_g, act_n, act_g);
            stop_failed();
        end
    endtask

    // outputs are registered, so mid-cycle is stable
    always @(negedge clk) begin
        if (out_valid_order) begin
            if (orders_seen >= exp_success.size()) begin
                $display("%s: order result arrived with no order outstanding", test_name);
                stop_failed();
            end else begin
                check_order(exp_success[orders_seen], success);
                orders_seen = orders_seen + 1;
            end
        end
        if (out_valid_tot) begin
            if (totals_seen >= exp_sold.size()) begin
                $display("%s: report arrived while a session was still open", test_name);
                stop_failed();
            end else begin
                check_total(exp_sold[totals_seen], exp_gain[totals_seen], sold_num, total_gain);
                totals_seen = totals_seen + 1;
            end
        end
    end

    task automatic next_edge();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_results();
        int n;
        n = 0;
        while (orders_seen < exp_success.size() || totals_seen < exp_sold.size()) begin
            if (n == WAIT_LIMIT) begin
                $display("%s: expected result missing after %0d cycles", test_name, n);
                stop_failed();
            end else begin
                @(posedge clk);
                n++;
            end
        end
        #1;
    endtask

    task automatic start_session();
        model_stock  = ramen_pkg::default_stock;
        model_counts = '0;
        model_gain   = '0;
    endtask

    task automatic expect_report();
        exp_sold.push_back(model_counts);
        exp_gain.push_back(model_gain);
    endtask

    // end_now drops selling so the FSM leaves straight from commit
    task automatic place_order(ramen_pkg::ramen_type_t t, logic p, logic end_now);
        ramen_pkg::order_t o;
        o.bowl    = t;
        o.portion = p;
        exp_success.push_back(serve_order(o));
        selling    = 1'b1;
        in_valid   = 1'b1;
        ramen_type = t;
        portion    = ~p;
        next_edge();
        ramen_type = ramen_pkg::ramen_type_t'(2'(int'(t) + 1));
        portion    = p;
        next_edge();
        in_valid = 1'b0;
        next_edge();
        if (end_now) begin
            selling = 1'b0;
            expect_report();
        end
        wait_results();
    endtask

    task automatic close_session();
        selling = 1'b0;
        expect_report();
        wait_results();
    endtask

    initial begin
        int   n_orders;
        logic early;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        selling    = 1'b0;
        portion    = 1'b0;
        ramen_type = ramen_pkg::tonkotsu;
        lfsr       = 32'he2f629a4;
        test_name  = "reset";
        start_session();
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_edge();

        test_name = "all_bowls";
        start_session();
        for (int k = 0; k < 8; k++) begin
            place_order(ramen_pkg::ramen_type_t'(2'(k >> 1)), 1'(k), 1'b0);
        end
        close_session();

        // 1000 miso covers 20 large bowls only
        test_name = "miso_out";
        start_session();
        repeat (21) place_order(ramen_pkg::miso, 1'b1, 1'b0);
        test_name = "after_fail";
        place_order(ramen_pkg::tonkotsu, 1'b0, 1'b0);
        // miso left at zero by the refused bowl
        place_order(ramen_pkg::miso, 1'b0, 1'b0);
        close_session();

        test_name = "second_session";
        start_session();
        place_order(ramen_pkg::tonkotsu_soy, 1'b1, 1'b0);
        place_order(ramen_pkg::miso_soy, 1'b0, 1'b0);
        place_order(ramen_pkg::miso, 1'b0, 1'b1);

        test_name = "random";
        for (int s = 0; s < 4; s++) begin
            start_session();
            n_orders = take_bits(6) % 60 + 1;
            early    = 1'(take_bits(1));
            for (int i = 0; i < n_orders; i++) begin
                if (i > 0) begin
                    repeat (take_bits(2)) next_edge();
                end
                place_order(ramen_pkg::ramen_type_t'(2'(take_bits(2))), 1'(take_bits(1)),
                            early && i == n_orders - 1);
            end
            if (!early) begin
                close_session();
            end
        end

        repeat (4) next_edge();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/ramen_chk.sv ====
`default_nettype none

module ramen_chk (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 out_valid_order,
    input logic                 success,
    input logic                 out_valid_tot,
    input ramen_pkg::sold_num_t sold_num,
    input ramen_pkg::gain_t     total_gain
);

    timeunit 1ns;
    timeprecision 1ps;

    // one result pulse per order
    order_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid_order |=> !out_valid_order)
        else $error("out_valid_order held for two cycles");

    success_valid: assert property (@(posedge clk) disable iff (!rst_n)
        success |-> out_valid_order)
        else $error("success without out_valid_order");

    valid_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(out_valid_order && out_valid_tot))
        else $error("order result and report in the same cycle");

    report_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid_tot |-> (sold_num == '0 && total_gain == '0))
        else $error("report outputs nonzero outside out_valid_tot");

endmodule

bind ramen_top ramen_chk u_chk (
    .clk             (clk),
    .rst_n           (rst_n),
    .out_valid_order (out_valid_order),
    .success         (success),
    .out_valid_tot   (out_valid_tot),
    .sold_num        (sold_num),
    .total_gain      (total_gain)
);

`default_nettype wire

// ==== rtl/ramen_top.sv ====
`default_nettype none

module ramen_top #(
    parameter ramen_pkg::stock_t INIT_STOCK = ramen_pkg::default_stock
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  logic                   selling,
    input  logic                   portion,
    input  ramen_pkg::ramen_type_t ramen_type,
    output logic                   out_valid_order,
    output logic                   success,
    output logic                   out_valid_tot,
    output ramen_pkg::sold_num_t   sold_num,
    output ramen_pkg::gain_t       total_gain
);

    ramen_pkg::order_t order;
    logic              enough;
    logic              sell;
    logic              restock;
    logic              report;

    order_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .selling         (selling),
        .portion         (portion),
        .ramen_type      (ramen_type),
        .enough          (enough),
        .order           (order),
        .sell            (sell),
        .restock         (restock),
        .report          (report),
        .out_valid_order (out_valid_order),
        .success         (success)
    );

    ingredient_stock #(
        .INIT_STOCK (INIT_STOCK)
    ) u_stock (
        .clk     (clk),
        .rst_n   (rst_n),
        .order   (order),
        .sell    (sell),
        .restock (restock),
        .enough  (enough)
    );

    sales_ledger u_ledger (
        .clk           (clk),
        .rst_n         (rst_n),
        .order         (order),
        .sell          (sell),
        .restock       (restock),
        .report        (report),
        .out_valid_tot (out_valid_tot),
        .sold_num      (sold_num),
        .total_gain    (total_gain)
    );

endmodule

`default_nettype wire

// ==== rtl/sales_ledger.sv ====
`default_nettype none

module sales_ledger (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ramen_pkg::order_t    order,
    input  logic                 sell,
    input  logic                 restock,
    input  logic                 report,
    output logic                 out_valid_tot,
    output ramen_pkg::sold_num_t sold_num,
    output ramen_pkg::gain_t     total_gain
);

    ramen_pkg::sold_num_t counts;
    ramen_pkg::gain_t     takings;
    ramen_pkg::gain_t     price;

    // soy variants cost more
    always_comb begin
        case (order.bowl)
            ramen_pkg::tonkotsu_soy,
            ramen_pkg::miso_soy: price = ramen_pkg::price_soy;
            default:             price = ramen_pkg::price_plain;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            counts  <= '0;
            takings <= '0;
        end else if (restock) begin
            counts  <= '0;
            takings <= '0;
        end else if (sell) begin
            takings <= takings + price;
            case (order.bowl)
                ramen_pkg::tonkotsu:     counts.tonkotsu <= counts.tonkotsu + 7'd1;
                ramen_pkg::tonkotsu_soy: counts.tonkotsu_soy <= counts.tonkotsu_soy + 7'd1;
                ramen_pkg::miso:         counts.miso <= counts.miso + 7'd1;
                default:                 counts.miso_soy <= counts.miso_soy + 7'd1;
            endcase
        end
    end

    // report stays zero outside its one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_tot <= 1'b0;
            sold_num      <= '0;
            total_gain    <= '0;
        end else begin
            out_valid_tot <= report;
            sold_num      <= report ? counts : '0;
            total_gain    <= report ? takings : '0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ingredient_stock.sv ====
`default_nettype none

module ingredient_stock #(
    parameter ramen_pkg::stock_t INIT_STOCK = ramen_pkg::default_stock
) (
    input  logic              clk,
    input  logic              rst_n,
    input  ramen_pkg::order_t order,
    input  logic              sell,
    input  logic              restock,
    output logic              enough
);

    ramen_pkg::stock_t stock;
    ramen_pkg::stock_t need;

    assign need = ramen_pkg::recipe_of(order);

    // every field has to cover the bowl
    assign enough = (stock.noodle >= need.noodle) &&
                    (stock.broth  >= need.broth)  &&
                    (stock.soup   >= need.soup)   &&
                    (stock.miso   >= need.miso)   &&
                    (stock.soy    >= need.soy);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stock <= INIT_STOCK;
        end else if (restock) begin
            stock <= INIT_STOCK;
        end else if (sell) begin
            // sell only comes after enough was seen, so no underflow
            stock.noodle <= stock.noodle - need.noodle;
            stock.broth  <= stock.broth - need.broth;
            stock.soup   <= stock.soup - need.soup;
            stock.miso   <= stock.miso - need.miso;
            stock.soy    <= stock.soy - need.soy;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/order_ctrl.sv ====
`default_nettype none

module order_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  logic                   selling,
    input  logic                   portion,
    input  ramen_pkg::ramen_type_t ramen_type,
    input  logic                   enough,
    output ramen_pkg::order_t      order,
    output logic                   sell,
    output logic                   restock,
    output logic                   report,
    output logic                   out_valid_order,
    output logic                   success
);

    typedef enum logic [2:0] {
        idle,
        take_portion,
        check,
        commit,
        wait_next,
        total
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   verdict;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            idle:         state_nxt = in_valid ? take_portion : idle;
            take_portion: state_nxt = check;
            check:        state_nxt = commit;
            commit:       state_nxt = selling ? wait_next : total;
            wait_next: begin
                // a new order wins over the end of the session
                if (in_valid) begin
                    state_nxt = take_portion;
                end else if (!selling) begin
                    state_nxt = total;
                end
            end
            total:        state_nxt = idle;
            default:      state_nxt = idle;
        endcase
    end

    // type on the first in_valid cycle, portion on the second
    always_ff @(posedge clk) begin
        if ((state == idle || state == wait_next) && in_valid) begin
            order.bowl <= ramen_type;
        end
        if (state == take_portion) begin
            order.portion <= portion;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            verdict <= 1'b0;
        end else if (state == check) begin
            verdict <= enough;
        end
    end

    assign sell    = (state == commit) && verdict;
    assign restock = (state == idle);
    assign report  = (state == total);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_order <= 1'b0;
            success         <= 1'b0;
        end else begin
            out_valid_order <= (state == commit);
            success         <= sell;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ramen_pkg.sv ====
`default_nettype none

package ramen_pkg;

    typedef enum logic [1:0] {
        tonkotsu     = 2'd0,
        tonkotsu_soy = 2'd1,
        miso         = 2'd2,
        miso_soy     = 2'd3
    } ramen_type_t;

    // portion 1 means large
    typedef struct packed {
        ramen_type_t bowl;
        logic        portion;
    } order_t;

    typedef logic [13:0] noodle_t;
    typedef logic [15:0] broth_t;
    typedef logic [13:0] soup_t;
    typedef logic [9:0]  miso_t;
    typedef logic [10:0] soy_t;

    typedef struct packed {
        noodle_t noodle;
        broth_t  broth;
        soup_t   soup;
        miso_t   miso;
        soy_t    soy;
    } stock_t;

    typedef logic [6:0]  count_t;
    typedef logic [14:0] gain_t;

    // tonkotsu lands in the top 7 bits
    typedef struct packed {
        count_t tonkotsu;
        count_t tonkotsu_soy;
        count_t miso;
        count_t miso_soy;
    } sold_num_t;

    localparam stock_t default_stock = '{
        noodle: 14'd12000,
        broth:  16'd41000,
        soup:   14'd9000,
        miso:   10'd1000,
        soy:    11'd1500
    };

    localparam gain_t price_plain = 15'd200;
    localparam gain_t price_soy   = 15'd250;

    // amounts one bowl consumes
    function automatic stock_t recipe_of(order_t o);
        stock_t r;
        r = '0;
        r.noodle = o.portion ? 14'd150 : 14'd100;
        case (o.bowl)
            tonkotsu: begin
                r.broth = o.portion ? 16'd500 : 16'd300;
                r.soup  = o.portion ? 14'd200 : 14'd150;
            end
            tonkotsu_soy: begin
                r.broth = o.portion ? 16'd500 : 16'd300;
                r.soup  = o.portion ? 14'd150 : 14'd100;
                r.soy   = o.portion ? 11'd50 : 11'd30;
            end
            miso: begin
                r.broth = o.portion ? 16'd650 : 16'd400;
                r.miso  = o.portion ? 10'd50 : 10'd30;
            end
            default: begin
                r.broth = o.portion ? 16'd500 : 16'd300;
                r.soup  = o.portion ? 14'd100 : 14'd70;
                r.soy   = o.portion ? 11'd25 : 11'd15;
                r.miso  = o.portion ? 10'd25 : 10'd15;
            end
        endcase
        return r;
    endfunction

endpackage

`default_nettype wire
